// ==== tb.f ====
+incdir+.
skinny_data_pkg.sv
skinny_ctrl_pkg.sv
skinny_round_ctrl.sv
skinny_round_counter.sv
skinny_sbox_layer.sv
skinny_round_datapath.sv
skinny_tweakey_schedule.sv
skinny_core.sv
tb_skinny_core.sv

// ==== Bender.yml ====
package:
  name: skinny_core

export_include_dirs:
  - .

sources:
  - skinny_data_pkg.sv
  - skinny_ctrl_pkg.sv
  - skinny_round_ctrl.sv
  - skinny_round_counter.sv
  - skinny_sbox_layer.sv
  - skinny_round_datapath.sv
  - skinny_tweakey_schedule.sv
  - skinny_core.sv
  - target: test
    files:
      - tb_skinny_core.sv

// ==== tb_skinny_core.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "skinny_cfg.svh"

module tb_skinny_core;
   import skinny_data_pkg::*;

   localparam int N_ENTRIES = 8;
   localparam int MAX_WAIT  = 100;
   // Tweakey cell permutation, source cell per destination cell
   localparam int TK_PERM [16] = '{9, 15, 8, 13, 10, 14, 12, 11, 0, 1, 2, 3, 4, 5, 6, 7};

   logic     clk;
   logic     rst;
   logic     start;
   block_t   plaintext;
   tweakey_t tweakey;
   logic     busy;
   logic     done;
   block_t   ciphertext;

   block_t   tbl_pt  [N_ENTRIES];
   tweakey_t tbl_tk  [N_ENTRIES];
   int       tbl_gap [N_ENTRIES] = '{2, 0, 3, 0, 1, 5, 0, 2}; // Zero gap means back-to-back
   block_t   tbl_exp [N_ENTRIES];

   skinny_core DUT (
      .clk        (clk),
      .rst        (rst),
      .start      (start),
      .plaintext  (plaintext),
      .tweakey    (tweakey),
      .busy       (busy),
      .done       (done),
      .ciphertext (ciphertext)
   );

   always #20 clk = ~clk;

   function automatic block_t rand_block();
      return {$urandom(), $urandom(), $urandom(), $urandom()};
   endfunction

   // Four NOR/XOR layers, bit shuffle between them, bits 1 and 2 swapped at the end
   function automatic logic [7:0] sbox_ref(input logic [7:0] x);
      logic [7:0] y;
      y = x;
      for (int n = 0; n < 4; n++) begin
         y[4] = y[4] ^ ~(y[7] | y[6]);
         y[0] = y[0] ^ ~(y[3] | y[2]);
         if (n < 3) begin
            y = {y[2], y[1], y[7], y[6], y[4], y[0], y[3], y[5]};
         end else begin
            y = {y[7:3], y[1], y[2], y[0]};
         end
      end
      return y;
   endfunction

   function automatic block_t encrypt_ref(input block_t pt, input tweakey_t tk);
      logic [7:0] s [16];
      logic [7:0] t [16];
      logic [7:0] k [3][16];
      logic [5:0] rc;
      block_t     ct;
      for (int i = 0; i < 16; i++) begin
         s[i]    = pt[127-8*i -: 8];
         k[0][i] = tk.tk1[127-8*i -: 8];
         k[1][i] = tk.tk2[127-8*i -: 8];
         k[2][i] = tk.tk3[127-8*i -: 8];
      end
      rc = '0;
      for (int r = 0; r < `SKINNY_ROUNDS; r++) begin
         rc = {rc[4:0], rc[5] ^ rc[4] ^ 1'b1};
         for (int i = 0; i < 16; i++) begin
            s[i] = sbox_ref(s[i]);
            if (i < 8) begin
               s[i] = s[i] ^ k[0][i] ^ k[1][i] ^ k[2][i];
            end
         end
         s[0] = s[0] ^ {4'h0, rc[3:0]};
         s[4] = s[4] ^ {6'h0, rc[5:4]};
         s[8] = s[8] ^ 8'h02;
         for (int i = 0; i < 16; i++) begin
            t[i] = s[4*(i/4) + (i - i/4) % 4]; // Row r right by r
         end
         for (int c = 0; c < 4; c++) begin
            s[c]    = t[c] ^ t[8+c] ^ t[12+c];
            s[4+c]  = t[c];
            s[8+c]  = t[4+c] ^ t[8+c];
            s[12+c] = t[c] ^ t[8+c];
         end
         for (int j = 0; j < 3; j++) begin
            for (int i = 0; i < 16; i++) begin
               t[i] = k[j][TK_PERM[i]];
            end
            for (int i = 0; i < 16; i++) begin
               k[j][i] = t[i];
               if (i < 8 && j == 1) begin
                  k[j][i] = {t[i][6:0], t[i][7] ^ t[i][5]};
               end
               if (i < 8 && j == 2) begin
                  k[j][i] = {t[i][0] ^ t[i][6], t[i][7:1]};
               end
            end
         end
      end
      for (int i = 0; i < 16; i++) begin
         ct[127-8*i -: 8] = s[i];
      end
      return ct;
   endfunction

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("*** FAILED ***");
      $fatal(1, "stopping on first error");
   endtask

   task automatic check_eq(input logic [127:0] got, input logic [127:0] exp, input string what);
      if (got !== exp) begin
         fail_run($sformatf("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp));
      end
   endtask

   task automatic run_entry(input int i);
      int n;
      @(posedge clk);
      start     <= 1'b1;
      plaintext <= tbl_pt[i];
      tweakey   <= tbl_tk[i];
      @(posedge clk); // Edge that samples start
      start     <= 1'b0;
      plaintext <= rand_block(); // Inputs are junk from here on
      tweakey   <= {rand_block(), rand_block(), rand_block()};
      n = 0;
      @(negedge clk);
      while (!done) begin
         check_eq(busy, 1'b1, "busy during rounds");
         if (n == MAX_WAIT) begin
            fail_run($sformatf("Timeout: done never arrived for entry %0d", i));
         end
         @(posedge clk);
         start <= (i % 2 == 1) && (n == 10); // Stray start while busy
         n++;
         @(negedge clk);
      end
      check_eq(n, `SKINNY_ROUNDS, "cycles from start to done");
      check_eq(busy, 1'b0, "busy at done");
      check_eq(ciphertext, tbl_exp[i], $sformatf("ciphertext of entry %0d", i));
   endtask

   // Done drops, ciphertext holds
   task automatic check_idle(input int i, input int cycles);
      for (int c = 0; c < cycles; c++) begin
         @(posedge clk);
         @(negedge clk);
         check_eq(done, 1'b0, "done after its cycle");
         check_eq(busy, 1'b0, "busy while idle");
         check_eq(ciphertext, tbl_exp[i], "ciphertext held while idle");
      end
   endtask

   initial begin
      void'($urandom(81892));
      clk       = 1'b0;
      rst       = 1'b1;
      start     = 1'b0;
      plaintext = '0;
      tweakey   = '0;
      tbl_pt[0] = '0;
      tbl_tk[0] = '0;
      tbl_pt[1] = '1;
      tbl_tk[1] = '1;
      for (int i = 2; i < N_ENTRIES; i++) begin
         tbl_pt[i] = rand_block();
         tbl_tk[i] = {rand_block(), rand_block(), rand_block()};
      end
      for (int i = 0; i < N_ENTRIES; i++) begin
         tbl_exp[i] = encrypt_ref(tbl_pt[i], tbl_tk[i]);
      end
      repeat (10) @(posedge clk);
      rst <= 1'b0;
      for (int c = 0; c < 3; c++) begin
         @(negedge clk);
         check_eq(busy, 1'b0, "busy after reset");
         check_eq(done, 1'b0, "done after reset");
      end
      for (int i = 0; i < N_ENTRIES; i++) begin
         run_entry(i);
         check_idle(i, tbl_gap[i]);
      end
      $display("*** PASSED ***");
      $finish;
   end

endmodule

`default_nettype wire

// ==== skinny_core.sv ====
`timescale 1ns/10ps
`default_nettype none

module skinny_core (
   input  wire logic                     clk,
   input  wire logic                     rst,
   input  wire logic                     start,
   input  wire skinny_data_pkg::block_t   plaintext,
   input  wire skinny_data_pkg::tweakey_t tweakey,
   output logic                          busy,
   output logic                          done,
   output skinny_data_pkg::block_t        ciphertext
);
   import skinny_data_pkg::*;

   logic     load;
   logic     advance;
   logic     last_round;
   rc_t      rc;
   tweakey_t round_tk;

   skinny_round_ctrl u_ctrl (
      .clk        (clk),
      .rst        (rst),
      .start      (start),
      .last_round (last_round),
      .load       (load),
      .advance    (advance),
      .busy       (busy),
      .done       (done)
   );

   skinny_round_counter u_counter (
      .clk        (clk),
      .rst        (rst),
      .load       (load),
      .advance    (advance),
      .rc         (rc),
      .last_round (last_round)
   );

   skinny_tweakey_schedule u_schedule (
      .clk      (clk),
      .rst      (rst),
      .load     (load),
      .advance  (advance),
      .tweakey  (tweakey),
      .round_tk (round_tk)
   );

   skinny_round_datapath u_datapath (
      .clk        (clk),
      .rst        (rst),
      .load       (load),
      .advance    (advance),
      .plaintext  (plaintext),
      .round_tk   (round_tk),
      .rc         (rc),
      .ciphertext (ciphertext)
   );

endmodule

`default_nettype wire

// ==== skinny_tweakey_schedule.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "skinny_cfg.svh"

module skinny_tweakey_schedule (
   input  wire logic                     clk,
   input  wire logic                     rst,
   input  wire logic                     load,
   input  wire logic                     advance,
   input  wire skinny_data_pkg::tweakey_t tweakey,
   output skinny_data_pkg::tweakey_t      round_tk
);
   import skinny_data_pkg::*;

   localparam int W     = `SKINNY_BLOCK_W;
   localparam int CW    = `SKINNY_CELL_W;
   localparam int CELLS = W / CW;

   // Source cell for each destination cell
   localparam int PERM [CELLS] = '{9, 15, 8, 13, 10, 14, 12, 11, 0, 1, 2, 3, 4, 5, 6, 7};

   tweakey_t tk_q;
   tweakey_t tk_p;
   tweakey_t tk_nxt;

   function automatic block_t permute(input block_t ki);
      block_t ko;
      for (int p = 0; p < CELLS; p++) begin
         ko[W-1-p*CW -: CW] = ki[W-1-PERM[p]*CW -: CW];
      end
      return ko;
   endfunction

   function automatic cell_t lfsr2(input cell_t x);
      return {x[6:0], x[7] ^ x[5]};
   endfunction

   function automatic cell_t lfsr3(input cell_t x);
      return {x[0] ^ x[6], x[7:1]};
   endfunction

   always_comb begin
      tk_p.tk1 = permute(tk_q.tk1);
      tk_p.tk2 = permute(tk_q.tk2);
      tk_p.tk3 = permute(tk_q.tk3);
      tk_nxt   = tk_p; // TK1 only permuted
      for (int p = 0; p < CELLS / 2; p++) begin
         tk_nxt.tk2[W-1-p*CW -: CW] = lfsr2(tk_p.tk2[W-1-p*CW -: CW]);
         tk_nxt.tk3[W-1-p*CW -: CW] = lfsr3(tk_p.tk3[W-1-p*CW -: CW]);
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         tk_q <= '0;
      end else if (load) begin
         tk_q <= tweakey;
      end else if (advance) begin
         tk_q <= tk_nxt;
      end
   end

   assign round_tk = tk_q;

endmodule

`default_nettype wire

// ==== skinny_round_datapath.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "skinny_cfg.svh"

module skinny_round_datapath (
   input  wire logic                     clk,
   input  wire logic                     rst,
   input  wire logic                     load,
   input  wire logic                     advance,
   input  wire skinny_data_pkg::block_t   plaintext,
   input  wire skinny_data_pkg::tweakey_t round_tk,
   input  wire skinny_data_pkg::rc_t      rc,
   output skinny_data_pkg::block_t        ciphertext
);
   import skinny_data_pkg::*;

   block_t state_q;
   block_t sb;
   block_t tk_x;
   block_t rtk;
   block_t atk;
   block_t shr;
   block_t mxc;

   skinny_sbox_layer u_sbox (
      .state_in  (state_q),
      .state_out (sb)
   );

   assign tk_x = round_tk.tk1 ^ round_tk.tk2 ^ round_tk.tk3;

   // Top two rows of tweakey, constant in cells 0, 4 and 8
   assign rtk = {tk_x[127:64], 64'h0} ^
                {4'h0, rc[3:0], 24'h0, 6'h0, rc[5:4], 24'h0, 8'h02, 56'h0};

   assign atk = sb ^ rtk;

   // Row r rotated right by r cells
   assign shr[127:96] = atk[127:96];
   assign shr[95:64]  = {atk[71:64], atk[95:72]};
   assign shr[63:32]  = {atk[47:32], atk[63:48]};
   assign shr[31:0]   = {atk[23:0], atk[31:24]};

   assign mxc[127:96] = shr[127:96] ^ shr[63:32] ^ shr[31:0];
   assign mxc[95:64]  = shr[127:96];
   assign mxc[63:32]  = shr[95:64] ^ shr[63:32];
   assign mxc[31:0]   = shr[127:96] ^ shr[63:32];

   always_ff @(posedge clk) begin
      if (rst) begin
         state_q <= '0;
      end else if (load) begin
         state_q <= plaintext;
      end else if (advance) begin
         state_q <= mxc; // One full round
      end
   end

   assign ciphertext = state_q;

endmodule

`default_nettype wire

// ==== skinny_sbox_layer.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "skinny_cfg.svh"

module skinny_sbox_layer (
   input  wire skinny_data_pkg::block_t state_in,
   output skinny_data_pkg::block_t      state_out
);
   import skinny_data_pkg::*;

   localparam int CW    = `SKINNY_CELL_W;
   localparam int CELLS = `SKINNY_BLOCK_W / CW;

   // (x nor y) xor z
   function automatic logic cfn(input logic x, input logic y, input logic z);
      return ~(x | y) ^ z;
   endfunction

   function automatic cell_t sbox8(input cell_t si);
      logic [7:0] a;
      a[0] = cfn(si[7], si[6], si[4]);
      a[1] = cfn(si[3], si[2], si[0]);
      a[2] = cfn(si[2], si[1], si[6]);
      a[3] = cfn(a[0], a[1], si[5]);
      a[4] = cfn(a[1], si[3], si[1]);
      a[5] = cfn(a[2], a[3], si[7]);
      a[6] = cfn(a[3], a[0], si[3]);
      a[7] = cfn(a[4], a[5], si[2]);
      // Output bit order
      return {a[3], a[0], a[1], a[6], a[4], a[2], a[5], a[7]};
   endfunction

   for (genvar i = 0; i < CELLS; i++) begin : g_cell
      assign state_out[i*CW +: CW] = sbox8(state_in[i*CW +: CW]);
   end

endmodule

`default_nettype wire

// ==== skinny_round_counter.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "skinny_cfg.svh"

module skinny_round_counter (
   input  wire logic            clk,
   input  wire logic            rst,
   input  wire logic            load,
   input  wire logic            advance,
   output skinny_data_pkg::rc_t rc,
   output logic                 last_round
);
   import skinny_data_pkg::*;
   import skinny_ctrl_pkg::*;

   round_t round_idx;
   rc_t    lfsr;

   // Already stepped, first round sees 0x01
   assign rc = {lfsr[4:0], lfsr[5] ^ lfsr[4] ^ 1'b1};

   assign last_round = (round_idx == round_t'(`SKINNY_ROUNDS - 1));

   always_ff @(posedge clk) begin
      if (rst || load) begin
         round_idx <= '0;
         lfsr      <= '0;
      end else if (advance) begin
         round_idx <= round_idx + 1'b1;
         lfsr      <= rc;
      end
   end

   // Relies on the FSM dropping advance after the last round
   a_idx_bound: assert property (@(posedge clk) disable iff (rst)
      round_idx <= round_t'(`SKINNY_ROUNDS));

endmodule

`default_nettype wire

// ==== skinny_round_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "skinny_cfg.svh"

module skinny_round_ctrl (
   input  wire logic clk,
   input  wire logic rst,
   input  wire logic start,
   input  wire logic last_round,
   output logic      load,
   output logic      advance,
   output logic      busy,
   output logic      done
);
   import skinny_ctrl_pkg::*;

   ctrl_state_t state;
   ctrl_state_t state_nxt;

   assign load    = (state == st_idle) && start; // Start ignored unless idle
   assign advance = (state == st_run);
   assign busy    = (state == st_run);
   assign done    = (state == st_done);

   always_comb begin
      state_nxt = state;
      case (state)
         st_idle: begin
            if (start) begin
               state_nxt = st_run;
            end
         end
         st_run: begin
            if (last_round) begin
               state_nxt = st_done;
            end
         end
         default: state_nxt = st_idle; // Done lasts one cycle
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= st_idle;
      end else begin
         state <= state_nxt;
      end
   end

   // Accepted start gives exactly ROUNDS busy cycles, then done
   a_load_to_done: assert property (@(posedge clk) disable iff (rst)
      load |=> busy [*`SKINNY_ROUNDS] ##1 done);

   // Counter only flags the final round while rounds are running
   a_last_in_run: assert property (@(posedge clk) disable iff (rst)
      last_round |-> busy);

endmodule

`default_nettype wire

// ==== skinny_ctrl_pkg.sv ====
`default_nettype none

`include "skinny_cfg.svh"

package skinny_ctrl_pkg;

   typedef enum logic [1:0] {
      st_idle,
      st_run,
      st_done
   } ctrl_state_t;

   typedef logic [`SKINNY_ROUND_W-1:0] round_t;

endpackage

`default_nettype wire

// ==== skinny_data_pkg.sv ====
`default_nettype none

`include "skinny_cfg.svh"

package skinny_data_pkg;

   // Cell 0 sits in the top byte, cells run row-major
   typedef logic [`SKINNY_BLOCK_W-1:0] block_t;

   typedef logic [`SKINNY_CELL_W-1:0] cell_t;

   typedef logic [`SKINNY_RC_W-1:0] rc_t;

   typedef struct packed {
      block_t tk1; // Counter / tweak word
      block_t tk2; // Tweak word
      block_t tk3; // Key word
   } tweakey_t;

endpackage

`default_nettype wire

// ==== skinny_cfg.svh ====
`ifndef SKINNY_CFG_SVH
`define SKINNY_CFG_SVH

// SKINNY-128-384+ round count, as used by Romulus
`define SKINNY_ROUNDS 40

`define SKINNY_BLOCK_W 128
`define SKINNY_CELL_W 8

// Round constant LFSR
`define SKINNY_RC_W 6

// Wide enough to count up to SKINNY_ROUNDS
`define SKINNY_ROUND_W 6

`endif
